//--- sim/testdata_average.txt
// Columns: kind flag value, all hex.
// Kind 0 idle, 1 sample (flag is sof), 2 expected (flag is channel), 3 reset, 4 end.
// Constant 100 on channel 0, every sample with sof.
1 1 0064
2 0 0006
1 1 0064
2 0 000D
1 1 0064
2 0 0013
1 1 0064
2 0 0019
1 1 0064
2 0 001F
1 1 0064
2 0 0026
1 1 0064
2 0 002C
1 1 0064
2 0 0032
1 1 0064
2 0 0038
1 1 0064
2 0 003F
1 1 0064
2 0 0045
1 1 0064
2 0 004B
1 1 0064
2 0 0051
1 1 0064
2 0 0058
1 1 0064
2 0 005E
1 1 0064
2 0 0064
// Interleaved frames, channel 0 window now sliding.
1 1 0064
2 0 0064
1 0 1000
2 1 0100
1 0 F000
2 2 FF00
1 0 0023
2 3 0002
0 0 0000
1 1 0000
2 0 005E
1 0 0800
2 1 0180
0 1 0000
1 0 7FFF
2 2 0700
1 0 8000
2 3 F802
// Sof in mid-frame sends the sample back to channel 0.
1 0 0010
2 0 0059
1 0 FF00
2 1 0170
1 1 0010
2 0 0053
1 0 0001
2 1 0170
3 0 0000
// Fresh history, sums with low nibble 7, 8 and 9.
1 0 0007
2 0 0000
1 0 0008
2 1 0001
1 0 0009
2 2 0001
1 0 FFF7
2 3 FFFF
1 0 FFF1
2 0 0000
1 0 FFF1
2 1 0000
4 0 0000

//--- build.f
logic/mavg_pkg.sv
logic/window_ram.sv
logic/boxcar_lane.sv
logic/lane_dispatch.sv
logic/result_collect.sv
logic/multichannel_average.sv
sim/clock_gen.sv
sim/tb_multichannel_average.sv

//--- Makefile
TOP := tb_multichannel_average

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "Simulation reported failure, see sim.log"; \
		exit 1; \
	elif ! grep -q "Verification passed" sim.log; then \
		echo "Simulation ended without a result, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_multichannel_average.sv
module tb_multichannel_average
    import mavg_pkg::*;
();

    localparam string DATA_FILE = "sim/testdata_average.txt";
    localparam int SEED = 68;
    localparam int MAX_RECORDS = 128;
    localparam int CYCLES_PER_RECORD = 3 + TOTAL_LATENCY + 4;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 10;

    // Record kinds in the first column of the data file.
    localparam logic [SAMPLE_WIDTH-1:0] KIND_IDLE   = 16'h0000;
    localparam logic [SAMPLE_WIDTH-1:0] KIND_SAMPLE = 16'h0001;
    localparam logic [SAMPLE_WIDTH-1:0] KIND_EXPECT = 16'h0002;
    localparam logic [SAMPLE_WIDTH-1:0] KIND_RESET  = 16'h0003;
    localparam logic [SAMPLE_WIDTH-1:0] KIND_END    = 16'h0004;

    logic                           clk;
    logic                           rst;
    logic                           in_valid;
    logic                           in_sof;
    logic signed [SAMPLE_WIDTH-1:0] in_sample;
    logic                           out_valid;
    logic [CHAN_WIDTH-1:0]          out_channel;
    logic signed [SAMPLE_WIDTH-1:0] out_sample;

    logic [SAMPLE_WIDTH-1:0]        rec_mem [3*MAX_RECORDS];
    logic [CHAN_WIDTH-1:0]          exp_chan_q [$];
    logic signed [SAMPLE_WIDTH-1:0] exp_sample_q [$];
    int                             record_count;
    bit                             loaded = 1'b0;

    clock_gen clock_inst (
        .clk (clk)
    );

    multichannel_average multichannel_average_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_sof      (in_sof),
        .in_sample   (in_sample),
        .out_valid   (out_valid),
        .out_channel (out_channel),
        .out_sample  (out_sample)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_channel(input logic [CHAN_WIDTH-1:0] got,
                                 input logic [CHAN_WIDTH-1:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Mismatch at time %0t: output channel %0d, expected %0d",
                                        $time, got, expected));
        end
    endtask

    task automatic check_sample(input logic signed [SAMPLE_WIDTH-1:0] got,
                                input logic signed [SAMPLE_WIDTH-1:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Mismatch at time %0t: average %0d (0x%h), expected %0d (0x%h)",
                                        $time, got, got, expected, expected));
        end
    endtask

    // One input cycle, applied shortly after the rising edge.
    task automatic drive_cycle(input logic valid, input logic sof,
                               input logic [SAMPLE_WIDTH-1:0] sample);
        @(posedge clk);
        #(DRIVE_DELAY);
        in_valid  = valid;
        in_sof    = sof;
        in_sample = sample;
    endtask

    task automatic hold_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b1;
        hold_reset();
    endtask

    // Waits for queued results, bounded by the pipeline depth.
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_sample_q.size() != 0 && waited < TOTAL_LATENCY + 4) begin
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic load_records();
        int idx;
        $readmemh(DATA_FILE, rec_mem);
        record_count = -1;
        for (idx = 0; idx < MAX_RECORDS && record_count < 0; idx++) begin
            if (rec_mem[3*idx] === KIND_END) begin
                record_count = idx;
            end
        end
        if (record_count < 0) begin
            stop_with_failure("The data file has no end record.");
        end else begin
            loaded = 1'b1;
        end
    endtask

    // Outputs change on the rising edge, so sample them mid-cycle.
    always @(negedge clk) begin : output_monitor
        logic [CHAN_WIDTH-1:0]          exp_chan;
        logic signed [SAMPLE_WIDTH-1:0] exp_sample;
        if (rst === 1'b0 && out_valid === 1'b1) begin
            if (exp_sample_q.size() == 0) begin
                stop_with_failure($sformatf("Output strobe at time %0t with no result expected.",
                                            $time));
            end else begin
                exp_chan   = exp_chan_q.pop_front();
                exp_sample = exp_sample_q.pop_front();
                check_channel(out_channel, exp_chan);
                check_sample(out_sample, exp_sample);
            end
        end
    end

    initial begin : watchdog
        int limit_cycles;
        wait (loaded);
        limit_cycles = record_count * CYCLES_PER_RECORD;
        repeat (limit_cycles) @(posedge clk);
        stop_with_failure($sformatf("Timeout: records not finished within %0d cycles.",
                                    limit_cycles));
    end

    initial begin : stimulus
        int                      idx;
        int                      gaps;
        logic [SAMPLE_WIDTH-1:0] kind;
        logic [SAMPLE_WIDTH-1:0] flag;
        logic [SAMPLE_WIDTH-1:0] value;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_sof    = 1'b0;
        in_sample = '0;
        void'($urandom(SEED));
        load_records();
        hold_reset();
        for (idx = 0; idx < record_count; idx++) begin
            kind  = rec_mem[3*idx];
            flag  = rec_mem[3*idx+1];
            value = rec_mem[3*idx+2];
            case (kind)
                KIND_IDLE: drive_cycle(1'b0, flag[0], value);
                KIND_SAMPLE: begin
                    // Idle gaps must not disturb any lane.
                    gaps = int'($urandom % 4);
                    repeat (gaps) drive_cycle(1'b0, 1'b0, '0);
                    drive_cycle(1'b1, flag[0], value);
                end
                KIND_EXPECT: begin
                    exp_chan_q.push_back(flag[CHAN_WIDTH-1:0]);
                    exp_sample_q.push_back(value);
                end
                KIND_RESET: begin
                    drive_cycle(1'b0, 1'b0, '0);
                    wait_for_drain();
                    if (exp_sample_q.size() != 0) begin
                        stop_with_failure("Expected results still missing before the reset.");
                    end else begin
                        apply_reset();
                    end
                end
                default: stop_with_failure($sformatf("Unknown record kind %h in record %0d.",
                                                     kind, idx));
            endcase
        end
        drive_cycle(1'b0, 1'b0, '0);
        wait_for_drain();
        // Quiet window to catch stray strobes.
        repeat (TOTAL_LATENCY) @(posedge clk);
        if (exp_sample_q.size() != 0) begin
            stop_with_failure($sformatf("%0d expected results never came out.",
                                        exp_sample_q.size()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- sim/clock_gen.sv
module clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 50;

    // Free-running clock, low at time zero.
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

//--- logic/multichannel_average.sv
module multichannel_average
    import mavg_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  logic                           in_sof,
    input  logic signed [SAMPLE_WIDTH-1:0] in_sample,
    output logic                           out_valid,
    output logic [CHAN_WIDTH-1:0]          out_channel,
    output logic signed [SAMPLE_WIDTH-1:0] out_sample
);

    logic [NUM_LANES-1:0]              lane_valid;
    logic [SAMPLE_WIDTH-1:0]           lane_sample;
    logic [NUM_LANES-1:0]              avg_valid;
    logic [NUM_LANES*SAMPLE_WIDTH-1:0] avg_sample;

    lane_dispatch dispatch_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_sof      (in_sof),
        .in_sample   (in_sample),
        .lane_valid  (lane_valid),
        .lane_sample (lane_sample)
    );

    // One averaging lane per channel.
    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
        boxcar_lane lane_inst (
            .clk          (clk),
            .rst          (rst),
            .sample_valid (lane_valid[g]),
            .sample       (lane_sample),
            .avg_valid    (avg_valid[g]),
            .avg          (avg_sample[g*SAMPLE_WIDTH +: SAMPLE_WIDTH])
        );
    end

    result_collect collect_inst (
        .clk         (clk),
        .rst         (rst),
        .avg_valid   (avg_valid),
        .avg_sample  (avg_sample),
        .out_valid   (out_valid),
        .out_channel (out_channel),
        .out_sample  (out_sample)
    );

endmodule

//--- logic/result_collect.sv
module result_collect
    import mavg_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic [NUM_LANES-1:0]              avg_valid,
    input  logic [NUM_LANES*SAMPLE_WIDTH-1:0] avg_sample,
    output logic                              out_valid,
    output logic [CHAN_WIDTH-1:0]             out_channel,
    output logic [SAMPLE_WIDTH-1:0]           out_sample
);

    logic [CHAN_WIDTH-1:0]   sel_chan;
    logic [SAMPLE_WIDTH-1:0] sel_sample;

    // Encode the active lane and pick its result.
    always_comb begin
        sel_chan   = '0;
        sel_sample = avg_sample[SAMPLE_WIDTH-1:0];
        for (int i = 0; i < NUM_LANES; i++) begin
            if (avg_valid[i]) begin
                sel_chan   = CHAN_WIDTH'(i);
                sel_sample = avg_sample[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= |avg_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (|avg_valid) begin
            out_channel <= sel_chan;
            out_sample  <= sel_sample;
        end
    end

    // Equal lane latency keeps lane results from colliding.
    lane_result_single: assert property (@(posedge clk) disable iff (rst)
        $onehot0(avg_valid))
        else $error("Two lane results in one cycle.");

endmodule

//--- logic/lane_dispatch.sv
module lane_dispatch
    import mavg_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic                    in_sof,
    input  logic [SAMPLE_WIDTH-1:0] in_sample,
    output logic [NUM_LANES-1:0]    lane_valid,
    output logic [SAMPLE_WIDTH-1:0] lane_sample
);

    logic [CHAN_WIDTH-1:0] chan_pos;
    logic [CHAN_WIDTH-1:0] cur_chan;

    // Frame start forces this sample onto channel 0.
    assign cur_chan = in_sof ? '0 : chan_pos;

    always_ff @(posedge clk) begin
        if (rst) begin
            chan_pos   <= '0;
            lane_valid <= '0;
        end else begin
            lane_valid <= '0;
            if (in_valid) begin
                lane_valid[cur_chan] <= 1'b1;
                if (cur_chan == CHAN_WIDTH'(NUM_LANES - 1)) begin
                    chan_pos <= '0;
                end else begin
                    chan_pos <= cur_chan + 1'b1;
                end
            end
        end
    end

    // Shared sample bus, qualified by the lane strobes.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_sample <= in_sample;
        end
    end

    lane_strobe_single: assert property (@(posedge clk) disable iff (rst)
        $onehot0(lane_valid))
        else $error("More than one lane strobe raised.");

endmodule

//--- logic/boxcar_lane.sv
module boxcar_lane
    import mavg_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample_valid,
    input  logic [SAMPLE_WIDTH-1:0] sample,
    output logic                    avg_valid,
    output logic [SAMPLE_WIDTH-1:0] avg
);

    logic [WINDOW_LOG2-1:0]         wr_ptr;
    logic [WINDOW_LOG2-1:0]         rd_ptr;
    logic [WINDOW_LOG2:0]           fill_cnt;
    logic                           history_full;

    logic [RAM_LATENCY-1:0]         valid_pipe;
    logic [RAM_LATENCY-1:0]         full_pipe;
    logic [SAMPLE_WIDTH-1:0]        sample_pipe [RAM_LATENCY];
    logic [SAMPLE_WIDTH-1:0]        ram_rdata;

    logic signed [SAMPLE_WIDTH-1:0] new_sample;
    logic signed [SAMPLE_WIDTH-1:0] old_sample;
    logic                           valid_comb;
    logic signed [DIFF_WIDTH-1:0]   comb_diff;
    logic signed [ACC_WIDTH-1:0]    integ;

    assign history_full = (fill_cnt == (WINDOW_LOG2 + 1)'(WINDOW_LEN));

    // Read pointer runs one slot ahead of the write pointer.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= WINDOW_LOG2'(1);
            fill_cnt <= '0;
        end else if (sample_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
            rd_ptr <= rd_ptr + 1'b1;
            if (!history_full) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[RAM_LATENCY-2:0], sample_valid};
        end
    end

    // Sample and fill state ride along with the RAM read.
    always_ff @(posedge clk) begin
        sample_pipe[0] <= sample;
        full_pipe      <= {full_pipe[RAM_LATENCY-2:0], history_full};
        for (int i = 1; i < RAM_LATENCY; i++) begin
            sample_pipe[i] <= sample_pipe[i-1];
        end
    end

    // The write lands one cycle after the strobe, on the slot the read
    // already latched, so the read returns the sample from WINDOW_LEN
    // strobes back.
    window_ram ram_inst (
        .clk   (clk),
        .wen   (valid_pipe[0]),
        .waddr (wr_ptr),
        .wdata (sample_pipe[0]),
        .raddr (rd_ptr),
        .rdata (ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_comb <= 1'b0;
            avg_valid  <= 1'b0;
        end else begin
            valid_comb <= valid_pipe[RAM_LATENCY-1];
            avg_valid  <= valid_comb;
        end
    end

    assign new_sample = sample_pipe[RAM_LATENCY-1];

    // Zero history until the window has been filled once.
    assign old_sample = full_pipe[RAM_LATENCY-1] ? ram_rdata : '0;

    always_ff @(posedge clk) begin
        comb_diff <= {new_sample[SAMPLE_WIDTH-1], new_sample}
                   - {old_sample[SAMPLE_WIDTH-1], old_sample};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            integ <= '0;
        end else if (valid_comb) begin
            integ <= integ + {{(ACC_WIDTH - DIFF_WIDTH){comb_diff[DIFF_WIDTH-1]}}, comb_diff};
        end
    end

    // Round half up on the discarded fraction.
    assign avg = integ[ACC_WIDTH-1 -: SAMPLE_WIDTH]
               + {{(SAMPLE_WIDTH - 1){1'b0}}, integ[WINDOW_LOG2-1]};

    fill_bound: assert property (@(posedge clk) disable iff (rst)
        fill_cnt <= (WINDOW_LOG2 + 1)'(WINDOW_LEN))
        else $error("Fill counter beyond window length.");

endmodule

//--- logic/window_ram.sv
module window_ram
    import mavg_pkg::*;
(
    input  logic                    clk,
    input  logic                    wen,
    input  logic [WINDOW_LOG2-1:0]  waddr,
    input  logic [SAMPLE_WIDTH-1:0] wdata,
    input  logic [WINDOW_LOG2-1:0]  raddr,
    output logic [SAMPLE_WIDTH-1:0] rdata
);

    logic [SAMPLE_WIDTH-1:0] mem [WINDOW_LEN];
    logic [WINDOW_LOG2-1:0]  raddr_q;
    logic [SAMPLE_WIDTH-1:0] rd_pipe [RAM_LATENCY-1];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Address register, array read, then output stages.
    always_ff @(posedge clk) begin
        raddr_q    <= raddr;
        rd_pipe[0] <= mem[raddr_q];
        for (int i = 1; i < RAM_LATENCY - 1; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rdata = rd_pipe[RAM_LATENCY-2];

endmodule

//--- logic/mavg_pkg.sv
package mavg_pkg;

    // Interleaved channels per frame.
    localparam int NUM_LANES = 4;

    // Channel index width.
    localparam int CHAN_WIDTH = $clog2(NUM_LANES);

    // Signed sample width, input and output.
    localparam int SAMPLE_WIDTH = 16;

    // Boxcar window length in samples.
    localparam int WINDOW_LEN = 16;

    // Pointer width, also the normalizing shift.
    localparam int WINDOW_LOG2 = $clog2(WINDOW_LEN);

    // Comb difference carries one extra bit.
    localparam int DIFF_WIDTH = SAMPLE_WIDTH + 1;

    // Integrator holds the full window sum without overflow.
    localparam int ACC_WIDTH = SAMPLE_WIDTH + WINDOW_LOG2;

    // Read latency of the window RAM.
    localparam int RAM_LATENCY = 2;

    // Dispatch register, lane pipeline and collector register.
    localparam int TOTAL_LATENCY = 1 + RAM_LATENCY + 2 + 1;

endpackage
